/* Makefile */
VERILATOR ?= verilator
TOP       := fetch_cache_tb
FILELIST  := fetch_cache.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
             --top-module $(TOP) -Mdir $(OBJ_DIR)

SOURCES   := $(wildcard include/*.svh verilog/*.sv verification/*.sv)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* fetch_cache.f */
+incdir+include
verilog/icache_pkg.sv
verilog/icache_store.sv
verilog/icache_refill.sv
verilog/inst_memory.sv
verilog/fetch_cache_top.sv
verification/fetch_cache_assertions.sv
verification/fetch_cache_tb.sv

/* include/icache_macros.svh */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// fetch address split.
`define ADDR_LEN    32
`define OFFSET_LEN  4
`define INDEX_LEN   2
`define TAG_LEN     26

// cache geometry.
`define BLOCK_WORDS 4
`define LINES       4

// 1024 words of instruction memory.
`define MEM_AW      10

// response codes on rresp.
`define RESP_OKAY   2'd0
`define RESP_MISS   2'd2

`endif

/* verification/fetch_cache_assertions.sv */
module fetch_cache_assertions (
	input logic                    clock,
	input logic                    reset,
	input logic                    flush,
	input logic                    fetch_arready,
	input icache_pkg::cache_addr_u lk_araddr,
	input logic                    lk_arvalid,
	input logic                    lk_arready,
	input logic [31:0]             lk_rdata,
	input logic                    lk_rvalid,
	input logic                    lk_rready,
	input icache_pkg::cache_addr_u fill_awaddr,
	input logic                    fill_awvalid,
	input logic                    fill_awready,
	input logic [31:0]             fill_wdata,
	input logic                    fill_wvalid,
	input logic                    fill_wready,
	input logic                    fill_bvalid,
	input logic                    fill_bready
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0; // failed assertions so far.

	lk_ar_hold: assert property (@(posedge clock) disable iff (reset)
		lk_arvalid && !lk_arready |=> lk_arvalid && $stable(lk_araddr))
		else begin
			fail_count++;
			$error("lookup request dropped or changed before it was accepted");
		end

	lk_r_hold: assert property (@(posedge clock) disable iff (reset)
		lk_rvalid && !lk_rready |=> lk_rvalid && $stable(lk_rdata))
		else begin
			fail_count++;
			$error("lookup response dropped or changed before it was taken");
		end

	fill_aw_hold: assert property (@(posedge clock) disable iff (reset)
		fill_awvalid && !fill_awready |=> fill_awvalid && $stable(fill_awaddr))
		else begin
			fail_count++;
			$error("fill address dropped or changed before it was accepted");
		end

	fill_w_hold: assert property (@(posedge clock) disable iff (reset)
		fill_wvalid && !fill_wready |=> fill_wvalid && $stable(fill_wdata))
		else begin
			fail_count++;
			$error("fill data dropped or changed before it was accepted");
		end

	fill_b_hold: assert property (@(posedge clock) disable iff (reset)
		fill_bvalid && !fill_bready |=> fill_bvalid)
		else begin
			fail_count++;
			$error("fill write response dropped before it was taken");
		end

	lk_ready_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> lk_arready)
		else begin
			fail_count++;
			$error("store lookup channel not ready after reset");
		end

	flush_when_idle: assert property (@(posedge clock) disable iff (reset)
		flush |-> fetch_arready)
		else begin
			fail_count++;
			$error("flush raised while a fetch was in flight");
		end

endmodule

// the top level sees every channel between the three blocks.
bind fetch_cache_top fetch_cache_assertions i_assertions (.*);

/* verification/fetch_cache_tb.sv */
`include "icache_macros.svh"

module fetch_cache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import icache_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 10;
	localparam int MEM_WORDS    = 2**`MEM_AW;
	localparam int MISS_CYCLES  = 40; // bound on one refill plus lookups.
	localparam int HOLD_CYCLES  = 6;
	localparam int NUM_FETCHES  = 23;
	localparam int RUN_CYCLES   = RESET_CYCLES + MEM_WORDS + 8 +
		NUM_FETCHES * (MISS_CYCLES + HOLD_CYCLES);
	localparam logic [31:0] SEED = 32'h8876_78ec;

	logic                 clock;
	logic                 reset;
	logic [`ADDR_LEN-1:0] fetch_araddr;
	logic                 fetch_arvalid;
	logic                 fetch_arready;
	logic [31:0]          fetch_rdata;
	logic                 fetch_rvalid;
	logic                 fetch_rready;
	logic                 flush;
	logic                 load_en;
	logic [`ADDR_LEN-1:0] load_addr;
	logic [31:0]          load_data;

	logic [31:0] ref_mem [MEM_WORDS]; // mirror of every load write.

	fetch_cache_top i_dut (.*);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(2 * RUN_CYCLES * CLK_PERIOD);
		abort_run("watchdog expired before the tests finished");
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			abort_run($sformatf("Mismatch at %0d ns: %s, got %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			abort_run($sformatf("Mismatch at %0d ns: %s, got %b, expected %b",
				$time, what, actual, expected));
		end
	endtask

	// inputs change just after the edge, outputs are read there too.
	task automatic step();
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	function automatic cache_addr_u make_addr(input logic [`TAG_LEN-1:0] tag,
		input logic [`INDEX_LEN-1:0] index, input logic [`OFFSET_LEN-3:0] word);
		cache_addr_u a;
		a.raw     = '0;
		a.f.tag   = tag;
		a.f.index = index;
		a.f.word  = word;
		return a;
	endfunction

	// memory wraps at 4 KiB.
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return ref_mem[addr[`MEM_AW+1:2]];
	endfunction

	task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
		load_en   = 1'b1;
		load_addr = addr;
		load_data = data;
		step();
		load_en = 1'b0;
		ref_mem[addr[`MEM_AW+1:2]] = data;
	endtask

	task automatic fetch_word(input logic [31:0] addr, input int hold,
		output logic [31:0] data);
		int waited;
		logic [31:0] held;
		fetch_araddr  = addr;
		fetch_arvalid = 1'b1;
		waited = 0;
		while (!fetch_arready) begin
			if (waited == MISS_CYCLES) abort_run("fetch request was never accepted");
			step();
			waited++;
		end
		step(); // request taken on this edge.
		fetch_arvalid = 1'b0;
		waited = 0;
		while (!fetch_rvalid) begin
			if (waited == MISS_CYCLES) abort_run("no fetch response within the refill bound");
			step();
			waited++;
		end
		held = fetch_rdata;
		for (int i = 0; i < hold; i++) begin
			step();
			check_bit(fetch_rvalid, 1'b1, "rvalid under back-pressure");
			check_word(fetch_rdata, held, "rdata under back-pressure");
			check_bit(fetch_arready, 1'b0, "arready under back-pressure");
		end
		fetch_rready = 1'b1;
		data = fetch_rdata;
		step();
		fetch_rready = 1'b0;
		check_bit(fetch_rvalid, 1'b0, "rvalid after the response transfer");
	endtask

	task automatic do_flush();
		if (!fetch_arready) abort_run("flush requested while a fetch was in flight");
		flush = 1'b1;
		step();
		flush = 1'b0;
	endtask

	task automatic test_reset();
		check_bit(fetch_arready, 1'b1, "arready after reset");
		check_bit(fetch_rvalid, 1'b0, "rvalid after reset");
	endtask

	task automatic test_cold_miss();
		logic [31:0] addr;
		logic [31:0] got;
		for (int i = 0; i < MEM_WORDS; i++) begin
			load_word(32'(i) << 2, $urandom());
		end
		for (int n = 0; n < 8; n++) begin
			addr = $urandom() & 32'hffff_fffc;
			fetch_word(addr, 0, got);
			check_word(got, expected_word(addr), "cold miss fetch");
		end
	endtask

	task automatic test_line_fill();
		cache_addr_u base;
		cache_addr_u a;
		logic [31:0] got;
		do_flush();
		base.raw        = $urandom();
		base.f.word     = 2'd2;
		base.f.byte_off = 2'b00;
		fetch_word(base.raw, 0, got);
		check_word(got, expected_word(base.raw), "line fill miss");
		for (int w = 0; w < `BLOCK_WORDS; w++) begin
			a        = base;
			a.f.word = 2'(w);
			fetch_word(a.raw, 0, got);
			check_word(got, expected_word(a.raw), "word of the filled line");
		end
	endtask

	task automatic test_conflict();
		cache_addr_u a0;
		cache_addr_u a1;
		logic [31:0] got;
		a0.raw        = $urandom();
		a0.f.byte_off = 2'b00;
		a1 = make_addr(~a0.f.tag, a0.f.index, a0.f.word); // same line, other tag.
		for (int n = 0; n < 3; n++) begin
			fetch_word(a0.raw, 0, got);
			check_word(got, expected_word(a0.raw), "first conflicting address");
			fetch_word(a1.raw, 0, got);
			check_word(got, expected_word(a1.raw), "second conflicting address");
		end
	endtask

	task automatic test_stale_flush();
		cache_addr_u a;
		logic [31:0] old_word;
		logic [31:0] got;
		a.raw        = $urandom();
		a.f.byte_off = 2'b00;
		fetch_word(a.raw, 0, got);
		check_word(got, expected_word(a.raw), "fetch before rewrite");
		old_word = expected_word(a.raw);
		load_word(a.raw, ~old_word);
		fetch_word(a.raw, 0, got);
		check_word(got, old_word, "cached word after memory rewrite");
		do_flush();
		fetch_word(a.raw, 0, got);
		check_word(got, ~old_word, "fetch after flush");
	endtask

	task automatic test_back_pressure();
		logic [31:0] addr;
		logic [31:0] got;
		addr = $urandom() & 32'hffff_fffc;
		fetch_word(addr, HOLD_CYCLES, got);
		check_word(got, expected_word(addr), "fetch under back-pressure");
	endtask

	initial begin
		void'($urandom(SEED));
		reset         = 1'b1;
		fetch_araddr  = '0;
		fetch_arvalid = 1'b0;
		fetch_rready  = 1'b0;
		flush         = 1'b0;
		load_en       = 1'b0;
		load_addr     = '0;
		load_data     = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		reset = 1'b0;
		step();
		test_reset();
		test_cold_miss();
		test_line_fill();
		test_conflict();
		test_stale_flush();
		test_back_pressure();
		if (i_dut.i_assertions.fail_count != 0) begin
			abort_run("a protocol assertion failed during the run");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

/* verilog/fetch_cache_top.sv */
`include "icache_macros.svh"

module fetch_cache_top (
	input  logic                 clock,
	input  logic                 reset,

	input  logic [`ADDR_LEN-1:0] fetch_araddr,
	input  logic                 fetch_arvalid,
	output logic                 fetch_arready,
	output logic [31:0]          fetch_rdata,
	output logic                 fetch_rvalid,
	input  logic                 fetch_rready,

	input  logic                 flush,

	input  logic                 load_en,
	input  logic [`ADDR_LEN-1:0] load_addr,
	input  logic [31:0]          load_data
);
	import icache_pkg::*;

	// refill controller to store.
	cache_addr_u lk_araddr;
	logic        lk_arvalid;
	logic        lk_arready;
	logic [31:0] lk_rdata;
	logic [1:0]  lk_rresp;
	logic        lk_rvalid;
	logic        lk_rready;
	cache_addr_u fill_awaddr;
	logic        fill_awvalid;
	logic        fill_awready;
	logic [31:0] fill_wdata;
	logic [3:0]  fill_wstrb;
	logic        fill_wvalid;
	logic        fill_wready;
	logic        fill_bvalid;
	logic        fill_bready;

	// refill controller to memory.
	logic [`ADDR_LEN-1:0] mem_araddr;
	logic                 mem_arvalid;
	logic                 mem_arready;
	logic [31:0]          mem_rdata;
	logic                 mem_rvalid;
	logic                 mem_rready;

	icache_refill i_refill (.*);

	icache_store i_store (
		.*,
		.fill_bresp() // controller takes every fill as okay.
	);

	inst_memory i_memory (.*);

endmodule

/* verilog/icache_pkg.sv */
`include "icache_macros.svh"

package icache_pkg;

	// one fetch address, seen whole or split into cache fields.
	typedef union packed {
		logic [`ADDR_LEN-1:0] raw;
		struct packed {
			logic [`TAG_LEN-1:0]    tag;
			logic [`INDEX_LEN-1:0]  index;
			logic [`OFFSET_LEN-3:0] word;
			logic [1:0]             byte_off;
		} f;
	} cache_addr_u;

endpackage

/* verilog/icache_refill.sv */
`include "icache_macros.svh"

module icache_refill (
	input  logic                    clock,
	input  logic                    reset,

	input  logic [`ADDR_LEN-1:0]    fetch_araddr,
	input  logic                    fetch_arvalid,
	output logic                    fetch_arready,
	output logic [31:0]             fetch_rdata,
	output logic                    fetch_rvalid,
	input  logic                    fetch_rready,

	output icache_pkg::cache_addr_u lk_araddr,
	output logic                    lk_arvalid,
	input  logic                    lk_arready,
	input  logic [31:0]             lk_rdata,
	input  logic [1:0]              lk_rresp,
	input  logic                    lk_rvalid,
	output logic                    lk_rready,

	output icache_pkg::cache_addr_u fill_awaddr,
	output logic                    fill_awvalid,
	input  logic                    fill_awready,
	output logic [31:0]             fill_wdata,
	output logic [3:0]              fill_wstrb,
	output logic                    fill_wvalid,
	input  logic                    fill_wready,
	input  logic                    fill_bvalid,
	output logic                    fill_bready,

	output logic [`ADDR_LEN-1:0]    mem_araddr,
	output logic                    mem_arvalid,
	input  logic                    mem_arready,
	input  logic [31:0]             mem_rdata,
	input  logic                    mem_rvalid,
	output logic                    mem_rready
);
	import icache_pkg::*;

	localparam logic [3:0] S_IDLE    = 4'd0;
	localparam logic [3:0] S_LOOKUP  = 4'd1;
	localparam logic [3:0] S_LK_WAIT = 4'd2;
	localparam logic [3:0] S_MEM_AR  = 4'd3;
	localparam logic [3:0] S_MEM_R   = 4'd4;
	localparam logic [3:0] S_FILL_AW = 4'd5;
	localparam logic [3:0] S_FILL_W  = 4'd6;
	localparam logic [3:0] S_FILL_B  = 4'd7;
	localparam logic [3:0] S_RESP    = 4'd8;

	logic [3:0]             state_q;
	logic [`OFFSET_LEN-3:0] word_q;
	cache_addr_u            fetch_addr_q;
	cache_addr_u            line_addr;

	// word of the missing line currently being moved.
	always_comb begin
		line_addr            = fetch_addr_q;
		line_addr.f.word     = word_q;
		line_addr.f.byte_off = 2'b00;
	end

	assign fetch_arready = (state_q == S_IDLE);
	assign fetch_rvalid  = (state_q == S_RESP);

	assign lk_araddr  = fetch_addr_q;
	assign lk_arvalid = (state_q == S_LOOKUP);
	assign lk_rready  = (state_q == S_LK_WAIT);

	assign mem_araddr  = line_addr.raw;
	assign mem_arvalid = (state_q == S_MEM_AR);
	assign mem_rready  = (state_q == S_MEM_R);

	assign fill_awaddr  = line_addr;
	assign fill_awvalid = (state_q == S_FILL_AW);
	assign fill_wstrb   = 4'hf; // whole words only.
	assign fill_wvalid  = (state_q == S_FILL_W);
	assign fill_bready  = (state_q == S_FILL_B);

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= S_IDLE;
			word_q  <= '0;
		end else begin
			case (state_q)
				S_IDLE: if (fetch_arvalid) state_q <= S_LOOKUP;
				S_LOOKUP: if (lk_arready) state_q <= S_LK_WAIT;
				S_LK_WAIT: begin
					if (lk_rvalid) begin
						if (lk_rresp == `RESP_OKAY) begin
							state_q <= S_RESP;
						end else begin
							word_q  <= '0; // refill from the line start.
							state_q <= S_MEM_AR;
						end
					end
				end
				S_MEM_AR: if (mem_arready) state_q <= S_MEM_R;
				S_MEM_R: if (mem_rvalid) state_q <= S_FILL_AW;
				S_FILL_AW: if (fill_awready) state_q <= S_FILL_W;
				S_FILL_W: if (fill_wready) state_q <= S_FILL_B;
				S_FILL_B: begin
					if (fill_bvalid) begin
						if (word_q == (`OFFSET_LEN-2)'(`BLOCK_WORDS-1)) begin
							state_q <= S_LOOKUP; // line complete, look again.
						end else begin
							word_q  <= word_q + 1'b1;
							state_q <= S_MEM_AR;
						end
					end
				end
				S_RESP: if (fetch_rready) state_q <= S_IDLE;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_arvalid && fetch_arready) begin
			fetch_addr_q.raw <= fetch_araddr;
		end
		if (state_q == S_LK_WAIT && lk_rvalid) begin
			fetch_rdata <= lk_rdata;
		end
		if (mem_rvalid && mem_rready) begin
			fill_wdata <= mem_rdata;
		end
	end

endmodule

/* verilog/icache_store.sv */
`include "icache_macros.svh"

module icache_store (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    flush,

	input  icache_pkg::cache_addr_u lk_araddr,
	input  logic                    lk_arvalid,
	output logic                    lk_arready,

	output logic [31:0]             lk_rdata,
	output logic [1:0]              lk_rresp,
	output logic                    lk_rvalid,
	input  logic                    lk_rready,

	input  icache_pkg::cache_addr_u fill_awaddr,
	input  logic                    fill_awvalid,
	output logic                    fill_awready,

	input  logic [31:0]             fill_wdata,
	input  logic [3:0]              fill_wstrb,
	input  logic                    fill_wvalid,
	output logic                    fill_wready,

	output logic                    fill_bvalid,
	output logic [1:0]              fill_bresp,
	input  logic                    fill_bready
);
	import icache_pkg::*;

	logic [31:0]          data_q [`LINES][`BLOCK_WORDS];
	logic [`TAG_LEN-1:0]  tag_q [`LINES];
	logic [`LINES-1:0]    valid_q;
	cache_addr_u          aw_addr_q;

	logic lk_hit;
	logic ar_fire;
	logic r_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;

	assign ar_fire = lk_arvalid & lk_arready;
	assign r_fire  = lk_rvalid & lk_rready;
	assign aw_fire = fill_awvalid & fill_awready;
	assign w_fire  = fill_wvalid & fill_wready;
	assign b_fire  = fill_bvalid & fill_bready;

	assign lk_hit = valid_q[lk_araddr.f.index] &&
		(tag_q[lk_araddr.f.index] == lk_araddr.f.tag);

	assign fill_bresp = `RESP_OKAY; // fills never fail.

	// lookup channel handshake.
	always_ff @(posedge clock) begin
		if (reset) begin
			lk_arready <= 1'b1;
			lk_rvalid  <= 1'b0;
		end else begin
			if (ar_fire) begin
				lk_arready <= 1'b0;
				lk_rvalid  <= 1'b1;
			end else if (r_fire) begin
				lk_arready <= 1'b1; // open again next cycle.
				lk_rvalid  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			lk_rdata <= data_q[lk_araddr.f.index][lk_araddr.f.word];
			lk_rresp <= lk_hit ? `RESP_OKAY : `RESP_MISS;
		end
	end

	// fill channel, aw then w then b.
	always_ff @(posedge clock) begin
		if (reset) begin
			fill_awready <= 1'b1;
			fill_wready  <= 1'b0;
			fill_bvalid  <= 1'b0;
		end else begin
			if (aw_fire) begin
				fill_awready <= 1'b0;
				fill_wready  <= 1'b1;
			end
			if (w_fire) begin
				fill_wready <= 1'b0;
				fill_bvalid <= 1'b1;
			end
			if (b_fire) begin
				fill_bvalid  <= 1'b0;
				fill_awready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire) begin
			aw_addr_q <= fill_awaddr;
		end
	end

	always_ff @(posedge clock) begin
		if (w_fire) begin
			for (int b = 0; b < 4; b++) begin
				if (fill_wstrb[b]) begin
					data_q[aw_addr_q.f.index][aw_addr_q.f.word][8*b +: 8] <=
						fill_wdata[8*b +: 8];
				end
			end
			tag_q[aw_addr_q.f.index] <= aw_addr_q.f.tag;
		end
	end

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			valid_q <= '0; // flush acts like fence.i.
		end else if (w_fire) begin
			valid_q[aw_addr_q.f.index] <= 1'b1;
		end
	end

endmodule

/* verilog/inst_memory.sv */
`include "icache_macros.svh"

module inst_memory (
	input  logic                 clock,
	input  logic                 reset,

	input  logic [`ADDR_LEN-1:0] mem_araddr,
	input  logic                 mem_arvalid,
	output logic                 mem_arready,

	output logic [31:0]          mem_rdata,
	output logic                 mem_rvalid,
	input  logic                 mem_rready,

	input  logic                 load_en,
	input  logic [`ADDR_LEN-1:0] load_addr,
	input  logic [31:0]          load_data
);

	logic [31:0] ram_q [2**`MEM_AW];

	logic ar_fire;
	logic r_fire;

	assign ar_fire = mem_arvalid & mem_arready;
	assign r_fire  = mem_rvalid & mem_rready;

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_arready <= 1'b1;
			mem_rvalid  <= 1'b0;
		end else begin
			if (ar_fire) begin
				mem_arready <= 1'b0;
				mem_rvalid  <= 1'b1;
			end else if (r_fire) begin
				mem_arready <= 1'b1;
				mem_rvalid  <= 1'b0;
			end
		end
	end

	// byte address wraps modulo the ram size.
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			mem_rdata <= ram_q[mem_araddr[`MEM_AW+1:2]];
		end
	end

	// backdoor load port.
	always_ff @(posedge clock) begin
		if (load_en) begin
			ram_q[load_addr[`MEM_AW+1:2]] <= load_data;
		end
	end

endmodule
